//--- hw/rv_backend_pkg.sv
`default_nettype none

package rv_backend_pkg;

    localparam int XLEN = 32;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    typedef enum logic [2:0] {
        WB_ALU  = 3'd0,
        WB_LOAD = 3'd1,
        WB_PC4  = 3'd2,
        WB_IMM  = 3'd3,
        WB_CSR  = 3'd4
    } wb_sel_t;

    // Load/store width codes from funct3
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instruction;
        wb_sel_t         wb_sel;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] csr_read_data;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] store_data;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
    } mem_stage_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instruction;
        wb_sel_t         wb_sel;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] csr_read_data;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] load_data;
        logic            reg_write;
    } wb_stage_t;

    localparam mem_stage_t MEM_BUBBLE = '{
        pc: '0, instruction: NOP_INSTR, wb_sel: WB_ALU, imm: '0, csr_read_data: '0,
        alu_result: '0, store_data: '0, reg_write: 1'b0, mem_read: 1'b0, mem_write: 1'b0
    };

    localparam wb_stage_t WB_BUBBLE = '{
        pc: '0, instruction: NOP_INSTR, wb_sel: WB_ALU, imm: '0, csr_read_data: '0,
        alu_result: '0, load_data: '0, reg_write: 1'b0
    };

endpackage

`default_nettype wire

//--- hw/dmem_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dmem_if;

    logic                               we;
    logic [3:0]                         byte_en;
    logic [rv_backend_pkg::DMEM_AW-1:0] word_addr;
    logic [rv_backend_pkg::XLEN-1:0]    wdata;
    logic [rv_backend_pkg::XLEN-1:0]    rdata;

    modport requester (
        output we, byte_en, word_addr, wdata,
        input  rdata
    );

    modport memory (
        input  we, byte_en, word_addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- hw/pipe_stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_stage_reg #(
    parameter type payload_t = logic [31:0],
    parameter payload_t BUBBLE = '0
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Flush wins over stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= BUBBLE;
        end else if (flush) begin
            q <= BUBBLE;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_store_unit (
    input  rv_backend_pkg::mem_stage_t mem_in,
    dmem_if.requester                  dmem,
    output rv_backend_pkg::wb_stage_t  wb_out
);

    logic [2:0]                      funct3;
    logic [1:0]                      addr_lo;
    logic [rv_backend_pkg::XLEN-1:0] shifted;
    logic [rv_backend_pkg::XLEN-1:0] extended;

    assign funct3  = mem_in.instruction[14:12];
    assign addr_lo = mem_in.alu_result[1:0];

    // Upper address bits beyond the RAM size wrap around
    assign dmem.word_addr = mem_in.alu_result[rv_backend_pkg::DMEM_AW+1:2];
    assign dmem.we        = mem_in.mem_write;

    // Store lanes
    always_comb begin
        case (funct3)
            rv_backend_pkg::F3_B: begin
                dmem.byte_en = 4'b0001 << addr_lo;
                dmem.wdata   = {4{mem_in.store_data[7:0]}};
            end
            rv_backend_pkg::F3_H: begin
                dmem.byte_en = addr_lo[1] ? 4'b1100 : 4'b0011;
                dmem.wdata   = {2{mem_in.store_data[15:0]}};
            end
            default: begin
                dmem.byte_en = 4'b1111;
                dmem.wdata   = mem_in.store_data;
            end
        endcase
    end

    // Addressed byte or half lands in the low bits
    assign shifted = dmem.rdata >> {addr_lo, 3'b000};

    always_comb begin
        case (funct3)
            rv_backend_pkg::F3_B:  extended = {{24{shifted[7]}}, shifted[7:0]};
            rv_backend_pkg::F3_BU: extended = {24'b0, shifted[7:0]};
            rv_backend_pkg::F3_H:  extended = {{16{shifted[15]}}, shifted[15:0]};
            rv_backend_pkg::F3_HU: extended = {16'b0, shifted[15:0]};
            default:               extended = shifted;
        endcase
    end

    always_comb begin
        wb_out.pc            = mem_in.pc;
        wb_out.instruction   = mem_in.instruction;
        wb_out.wb_sel        = mem_in.wb_sel;
        wb_out.imm           = mem_in.imm;
        wb_out.csr_read_data = mem_in.csr_read_data;
        wb_out.alu_result    = mem_in.alu_result;
        wb_out.load_data     = mem_in.mem_read ? extended : '0;
        wb_out.reg_write     = mem_in.reg_write;
    end

endmodule

`default_nettype wire

//--- hw/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram (
    input logic    clk,
    dmem_if.memory dmem
);

    logic [3:0][7:0] mem [rv_backend_pkg::DMEM_WORDS];

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        if (dmem.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dmem.byte_en[lane]) begin
                    mem[dmem.word_addr][lane] <= dmem.wdata[8*lane +: 8];
                end
            end
        end
    end

    // Asynchronous read
    assign dmem.rdata = mem[dmem.word_addr];

endmodule

`default_nettype wire

//--- hw/writeback_select.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_select (
    input  rv_backend_pkg::wb_stage_t       wb_in,
    output logic [4:0]                      rd_addr,
    output logic                            rd_we,
    output logic [rv_backend_pkg::XLEN-1:0] rd_data
);

    logic [rv_backend_pkg::XLEN-1:0] pc_plus_4;

    assign pc_plus_4 = wb_in.pc + rv_backend_pkg::XLEN'(4);
    assign rd_addr   = wb_in.instruction[11:7];

    // x0 writes are dropped here
    assign rd_we = wb_in.reg_write && (rd_addr != 5'd0);

    always_comb begin
        case (wb_in.wb_sel)
            rv_backend_pkg::WB_LOAD: rd_data = wb_in.load_data;
            rv_backend_pkg::WB_PC4:  rd_data = pc_plus_4;
            rv_backend_pkg::WB_IMM:  rd_data = wb_in.imm;
            rv_backend_pkg::WB_CSR:  rd_data = wb_in.csr_read_data;
            default:                 rd_data = wb_in.alu_result;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            we,
    input  logic [4:0]                      waddr,
    input  logic [rv_backend_pkg::XLEN-1:0] wdata,
    input  logic [4:0]                      raddr_a,
    output logic [rv_backend_pkg::XLEN-1:0] rdata_a,
    input  logic [4:0]                      raddr_b,
    output logic [rv_backend_pkg::XLEN-1:0] rdata_b
);

    logic [rv_backend_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through when reading the register being written
    function automatic logic [rv_backend_pkg::XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (we && (addr == waddr)) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata_a = read_port(raddr_a);
    end

    always_comb begin
        rdata_b = read_port(raddr_b);
    end

endmodule

`default_nettype wire

//--- hw/rv_backend.sv
`timescale 1ns/10ps
`default_nettype none

module rv_backend (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            stall,
    input  logic                            flush,
    input  logic [rv_backend_pkg::XLEN-1:0] in_pc,
    input  logic [31:0]                     in_instruction,
    input  rv_backend_pkg::wb_sel_t         in_wb_sel,
    input  logic [rv_backend_pkg::XLEN-1:0] in_imm,
    input  logic [rv_backend_pkg::XLEN-1:0] in_csr_read_data,
    input  logic [rv_backend_pkg::XLEN-1:0] in_alu_result,
    input  logic [rv_backend_pkg::XLEN-1:0] in_store_data,
    input  logic                            in_reg_write,
    input  logic                            in_mem_read,
    input  logic                            in_mem_write,
    input  logic [4:0]                      rf_raddr_a,
    input  logic [4:0]                      rf_raddr_b,
    output logic [rv_backend_pkg::XLEN-1:0] wb_pc,
    output logic [31:0]                     wb_instruction,
    output logic                            wb_reg_write,
    output logic [4:0]                      wb_rd,
    output logic [rv_backend_pkg::XLEN-1:0] wb_data,
    output logic [rv_backend_pkg::XLEN-1:0] rf_rdata_a,
    output logic [rv_backend_pkg::XLEN-1:0] rf_rdata_b
);

    rv_backend_pkg::mem_stage_t ex_payload;
    rv_backend_pkg::mem_stage_t mem_payload;
    rv_backend_pkg::wb_stage_t  mem_result;
    rv_backend_pkg::wb_stage_t  wb_payload;

    dmem_if dmem_bus ();

    assign ex_payload = '{
        pc: in_pc, instruction: in_instruction, wb_sel: in_wb_sel, imm: in_imm,
        csr_read_data: in_csr_read_data, alu_result: in_alu_result,
        store_data: in_store_data, reg_write: in_reg_write, mem_read: in_mem_read,
        mem_write: in_mem_write
    };

    pipe_stage_reg #(
        .payload_t (rv_backend_pkg::mem_stage_t),
        .BUBBLE    (rv_backend_pkg::MEM_BUBBLE)
    ) i_ex_mem (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (flush),
        .d     (ex_payload),
        .q     (mem_payload)
    );

    load_store_unit i_load_store_unit (
        .mem_in (mem_payload),
        .dmem   (dmem_bus),
        .wb_out (mem_result)
    );

    data_ram i_data_ram (
        .clk  (clk),
        .dmem (dmem_bus)
    );

    pipe_stage_reg #(
        .payload_t (rv_backend_pkg::wb_stage_t),
        .BUBBLE    (rv_backend_pkg::WB_BUBBLE)
    ) i_mem_wb (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (flush),
        .d     (mem_result),
        .q     (wb_payload)
    );

    assign wb_pc          = wb_payload.pc;
    assign wb_instruction = wb_payload.instruction;

    writeback_select i_writeback_select (
        .wb_in   (wb_payload),
        .rd_addr (wb_rd),
        .rd_we   (wb_reg_write),
        .rd_data (wb_data)
    );

    register_file i_register_file (
        .clk     (clk),
        .reset   (reset),
        .we      (wb_reg_write),
        .waddr   (wb_rd),
        .wdata   (wb_data),
        .raddr_a (rf_raddr_a),
        .rdata_a (rf_rdata_a),
        .raddr_b (rf_raddr_b),
        .rdata_b (rf_rdata_b)
    );

endmodule

`default_nettype wire

//--- sim/tb_rv_backend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_backend;

    logic clk, reset, stall, flush, in_reg_write, in_mem_read, in_mem_write, wb_reg_write;
    logic [31:0] in_pc, in_instruction, in_imm, in_csr_read_data, in_alu_result, in_store_data;
    rv_backend_pkg::wb_sel_t in_wb_sel;
    logic [4:0] rf_raddr_a, rf_raddr_b, wb_rd;
    logic [31:0] wb_pc, wb_instruction, wb_data, rf_rdata_a, rf_rdata_b;

    logic [31:0] seed = 32'hc26c_f9d0;
    logic [31:0] regs_model [32];
    logic [7:0]  ram_model [1024];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_pc [$];
    logic [4:0]  cur_rd;
    logic [31:0] cur_data;
    logic [31:0] cur_pc;
    bit stall_on, last_stall;
    int errors, err_mark, checks, bypass_checks;

    rv_backend i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Byte-addressed RAM model whose upper address bits wrap
    function automatic logic [31:0] load_model(input logic [2:0] f3, input logic [31:0] addr);
        logic [9:0]  a;
        logic [31:0] w;
        a = addr[9:0];
        w = {ram_model[a + 3], ram_model[a + 2], ram_model[a + 1], ram_model[a]};
        case (f3)
            rv_backend_pkg::F3_B:  return {{24{w[7]}}, w[7:0]};
            rv_backend_pkg::F3_BU: return {24'b0, w[7:0]};
            rv_backend_pkg::F3_H:  return {{16{w[15]}}, w[15:0]};
            rv_backend_pkg::F3_HU: return {16'b0, w[15:0]};
            default:               return w;
        endcase
    endfunction

    task automatic store_model(input logic [2:0] f3, input logic [31:0] addr,
                               input logic [31:0] d);
        int n;
        n = (f3 == rv_backend_pkg::F3_B) ? 1 : (f3 == rv_backend_pkg::F3_H) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ram_model[addr[9:0] + i] = d[8*i +: 8];
        end
    endtask

    function automatic logic [2:0] pick_width(input logic [31:0] r, input bit is_load);
        case (is_load ? r[31:28] % 5 : r[31:28] % 3)
            0:       return rv_backend_pkg::F3_B;
            1:       return rv_backend_pkg::F3_H;
            2:       return rv_backend_pkg::F3_W;
            3:       return rv_backend_pkg::F3_BU;
            default: return rv_backend_pkg::F3_HU;
        endcase
    endfunction

    function automatic logic [31:0] align(input logic [31:0] a, input logic [2:0] f3);
        if (f3 == rv_backend_pkg::F3_W) return a & ~32'h3;
        if (f3 == rv_backend_pkg::F3_H || f3 == rv_backend_pkg::F3_HU) return a & ~32'h1;
        return a;
    endfunction

    // Holds the instruction on the inputs until an unstalled edge takes it
    task automatic send(input logic [4:0] rd, input logic [2:0] f3,
                        input rv_backend_pkg::wb_sel_t sel, input logic [31:0] alu,
                        input logic [31:0] sdata, input logic rw, input logic mr,
                        input logic mw, input bit model);
        logic [31:0] pc, imm, csr, instr, val, r;
        bit s;
        int tries;
        pc = lcg() & ~32'h3;
        imm = lcg();
        csr = lcg();
        instr = lcg();
        instr[14:12] = f3;
        instr[11:7] = rd;
        instr[6:0] = 7'h33;
        if (model) begin
            case (sel)
                rv_backend_pkg::WB_LOAD: val = load_model(f3, alu);
                rv_backend_pkg::WB_PC4:  val = pc + 32'd4;
                rv_backend_pkg::WB_IMM:  val = imm;
                rv_backend_pkg::WB_CSR:  val = csr;
                default:                 val = alu;
            endcase
            if (mw) store_model(f3, alu, sdata);
            if (rw && rd != 5'd0) begin
                regs_model[rd] = val;
                exp_rd.push_back(rd);
                exp_data.push_back(val);
                exp_pc.push_back(pc);
            end
        end
        tries = 0;
        do begin
            @(posedge clk);
            r = lcg();
            s = stall_on && (r[31:30] == 2'd0) && (tries < 6);
            tries++;
            stall <= s;
            flush <= 1'b0;
            in_pc <= pc;
            in_instruction <= instr;
            in_wb_sel <= sel;
            in_imm <= imm;
            in_csr_read_data <= csr;
            in_alu_result <= alu;
            in_store_data <= sdata;
            in_reg_write <= rw;
            in_mem_read <= mr;
            in_mem_write <= mw;
            rf_raddr_a <= r[4:0];
            rf_raddr_b <= r[9:5];
        end while (s);
    endtask

    task automatic random_op(input bit mem_ops);
        logic [31:0] r, a;
        logic [2:0] f3;
        rv_backend_pkg::wb_sel_t sel;
        r = lcg();
        a = lcg() & 32'hffff_fc3f;
        f3 = pick_width(r, r[17]);
        case (r[9:8])
            2'd0:    sel = rv_backend_pkg::WB_ALU;
            2'd1:    sel = rv_backend_pkg::WB_PC4;
            2'd2:    sel = rv_backend_pkg::WB_IMM;
            default: sel = rv_backend_pkg::WB_CSR;
        endcase
        if (mem_ops && r[16] && r[17]) begin
            send(r[4:0], f3, rv_backend_pkg::WB_LOAD, align(a, f3), lcg(),
                 1'b1, 1'b1, 1'b0, 1'b1);
        end else if (mem_ops && r[16]) begin
            send(r[4:0], f3, rv_backend_pkg::WB_ALU, align(a, f3), lcg(),
                 1'b0, 1'b0, 1'b1, 1'b1);
        end else begin
            send(r[4:0], r[14:12], sel, lcg(), lcg(), r[10] | r[11], 1'b0, 1'b0, 1'b1);
        end
    endtask

    task automatic idle();
        @(posedge clk);
        stall <= 1'b0;
        flush <= 1'b0;
        in_instruction <= rv_backend_pkg::NOP_INSTR;
        in_reg_write <= 1'b0;
        in_mem_read <= 1'b0;
        in_mem_write <= 1'b0;
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        idle();
        while (exp_rd.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 50) begin
                $display("Timed out with %0d writebacks still pending", exp_rd.size());
                $display("TEST FAILED");
                $finish;
            end
        end
    endtask

    task automatic compare_regs();
        for (int i = 0; i < 32; i += 2) begin
            @(posedge clk);
            rf_raddr_a <= 5'(i);
            rf_raddr_b <= 5'(i + 1);
            @(negedge clk);
            check("rf_rdata_a", rf_rdata_a, regs_model[i]);
            check("rf_rdata_b", rf_rdata_b, regs_model[i + 1]);
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d, %s: %s", num, name, (errors == err_mark) ? "pass" : "fail");
        err_mark = errors;
    endtask

    // A held MEM/WB entry during stall is the same writeback, not a new one
    always @(negedge clk) begin
        if (!reset) begin
            if (wb_reg_write && !last_stall) begin
                if (exp_rd.size() == 0) begin
                    errors++;
                    $display("Writeback to x%0d at %0t was not expected", wb_rd, $time);
                end else begin
                    cur_rd = exp_rd.pop_front();
                    cur_data = exp_data.pop_front();
                    cur_pc = exp_pc.pop_front();
                    check("wb_rd", wb_rd, cur_rd);
                    check("wb_data", wb_data, cur_data);
                    check("wb_pc", wb_pc, cur_pc);
                end
            end
            if (wb_reg_write && rf_raddr_a == cur_rd) begin
                bypass_checks++;
                check("rf_rdata_a", rf_rdata_a, cur_data);
            end
            last_stall = stall;
        end
    end

    initial begin
        logic [31:0] r, a;
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        in_pc = '0;
        in_instruction = rv_backend_pkg::NOP_INSTR;
        in_wb_sel = rv_backend_pkg::WB_ALU;
        in_imm = '0;
        in_csr_read_data = '0;
        in_alu_result = '0;
        in_store_data = '0;
        in_reg_write = 1'b0;
        in_mem_read = 1'b0;
        in_mem_write = 1'b0;
        rf_raddr_a = '0;
        rf_raddr_b = '0;
        foreach (regs_model[i]) regs_model[i] = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        repeat (20) begin
            @(posedge clk);
            r = lcg();
            rf_raddr_a <= r[4:0];
            rf_raddr_b <= r[9:5];
            @(negedge clk);
            check("wb_reg_write", wb_reg_write, 32'd0);
            check("wb_instruction", wb_instruction, rv_backend_pkg::NOP_INSTR);
            check("rf_rdata_a", rf_rdata_a, 32'd0);
            check("rf_rdata_b", rf_rdata_b, 32'd0);
        end
        report_test(1, "reset state");

        repeat (200) random_op(1'b0);
        drain();
        compare_regs();
        report_test(2, "register writebacks");

        // Words 0 to 15 hold known data before any load
        for (int i = 0; i < 16; i++) begin
            send(5'd0, rv_backend_pkg::F3_W, rv_backend_pkg::WB_ALU, 32'(i) * 4, lcg(),
                 1'b0, 1'b0, 1'b1, 1'b1);
        end
        repeat (150) begin
            random_op(1'b1);
            r = lcg();
            if (r[0]) begin
                a = r & 32'hffff_fc3c;
                send(5'd0, pick_width(r, 1'b0), rv_backend_pkg::WB_ALU, a, lcg(),
                     1'b0, 1'b0, 1'b1, 1'b1);
                send(r[8:4], pick_width(lcg(), 1'b1), rv_backend_pkg::WB_LOAD, a, '0,
                     1'b1, 1'b1, 1'b0, 1'b1);
            end
        end
        drain();
        compare_regs();
        report_test(3, "loads and stores");

        stall_on = 1'b1;
        repeat (200) random_op(1'b1);
        drain();
        stall_on = 1'b0;
        compare_regs();
        report_test(4, "random stalls");

        // Flush edge drops the EX/MEM entry and the store on the inputs
        r = lcg();
        a = lcg() & 32'hffff_fc3c;
        send(r[4:0] | 5'd1, rv_backend_pkg::F3_W, rv_backend_pkg::WB_ALU, lcg(), '0,
             1'b1, 1'b0, 1'b0, 1'b0);
        send(5'd0, rv_backend_pkg::F3_W, rv_backend_pkg::WB_ALU, a, lcg(),
             1'b0, 1'b0, 1'b1, 1'b0);
        flush <= 1'b1;
        send(r[9:5] | 5'd2, rv_backend_pkg::F3_W, rv_backend_pkg::WB_LOAD, a, '0,
             1'b1, 1'b1, 1'b0, 1'b1);
        random_op(1'b0);
        drain();
        compare_regs();
        report_test(5, "flush");

        if (bypass_checks == 0) begin
            errors++;
            $display("No read of a register during its write was ever sampled");
        end
        report_test(6, "write-through read");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/rv_backend_pkg.sv
hw/dmem_if.sv
hw/pipe_stage_reg.sv
hw/load_store_unit.sv
hw/data_ram.sv
hw/writeback_select.sv
hw/register_file.sv
hw/rv_backend.sv
sim/tb_rv_backend.sv
